// File: compile.f
source/video_enc_pkg.sv
source/palette_sync.sv
source/color_lookup.sv
source/subcarrier_gen.sv
source/chroma_modulator.sv
source/composite_mixer.sv
source/composite_encoder_top.sv
verification/composite_encoder_tb.sv

// File: source/chroma_modulator.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_modulator (
        input  wire                                          clk_col16x,
        input  wire                                          rst_n_i,
        input  wire         [video_enc_pkg::LUMA_W-1:0]      luma_i,
        input  wire         [video_enc_pkg::AMP_W-1:0]       amp_i,
        input  wire         [video_enc_pkg::PHASE_W-1:0]     phase_i,
        input  wire         [video_enc_pkg::PHASE_W-1:0]     carrier_phase_i,
        input  wire                                          blank_i,
        input  wire                                          sync_i,
        input  wire                                          burst_i,
        output logic        [video_enc_pkg::LUMA_W-1:0]      luma_o,
        output logic signed [video_enc_pkg::CHROMA_W-1:0]    chroma_o,
        output logic                                         blank_o,
        output logic                                         sync_o,
        output logic                                         burst_o
);

        logic        [video_enc_pkg::PHASE_W-1:0]  total_phase;
        logic        [5:0]                         sine_idx;
        logic signed [video_enc_pkg::CHROMA_W-1:0] sine_val;
        logic signed [video_enc_pkg::CHROMA_W-1:0] scaled;

        assign total_phase = carrier_phase_i + phase_i;  // wraps at one turn
        assign sine_idx    = total_phase[video_enc_pkg::PHASE_W-1 -: 6];
        assign sine_val    = video_enc_pkg::SINE_TABLE[sine_idx];

        always_comb begin
                if (amp_i == video_enc_pkg::AMP_OFF)
                        scaled = '0;  // unmodulated colour
                else
                        scaled = sine_val >>> amp_i;  // halve per code step
        end

        always_ff @(posedge clk_col16x or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        luma_o   <= '0;
                        chroma_o <= '0;
                        blank_o  <= 1'b0;
                        sync_o   <= 1'b0;
                        burst_o  <= 1'b0;
                end else begin
                        luma_o   <= luma_i;
                        chroma_o <= scaled;
                        blank_o  <= blank_i;
                        sync_o   <= sync_i;
                        burst_o  <= burst_i;
                end
        end

endmodule

`default_nettype wire

// File: source/color_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module color_lookup (
        input  wire                                   clk_col16x,
        input  wire                                   rst_n_i,
        input  wire  [video_enc_pkg::INDEX_W-1:0]     index_i,
        input  wire                                   oddline_i,
        input  wire                                   blank_i,
        input  wire                                   sync_i,
        input  wire                                   burst_i,
        input  var   video_enc_pkg::luma_table_t      luma_table_i,
        input  var   video_enc_pkg::amp_table_t       amp_table_i,
        input  var   video_enc_pkg::phase_table_t     phase_table_i,
        output logic [video_enc_pkg::LUMA_W-1:0]      luma_o,
        output logic [video_enc_pkg::AMP_W-1:0]       amp_o,
        output logic [video_enc_pkg::PHASE_W-1:0]     phase_o,
        output logic                                  blank_o,
        output logic                                  sync_o,
        output logic                                  burst_o
);

        logic [video_enc_pkg::INDEX_W-1:0] slot;
        logic [video_enc_pkg::LUMA_W-1:0]  sel_luma;
        logic [video_enc_pkg::AMP_W-1:0]   sel_amp;
        logic [video_enc_pkg::PHASE_W-1:0] sel_phase;
        logic [video_enc_pkg::AMP_W-1:0]   next_amp;
        logic [video_enc_pkg::PHASE_W-1:0] base_phase;
        logic [video_enc_pkg::PHASE_W-1:0] next_phase;

        // entry 0 sits in the top field, so count slots from the bottom
        assign slot = video_enc_pkg::INDEX_W'(video_enc_pkg::NUM_COLORS - 1) - index_i;

        assign sel_luma  = luma_table_i[slot*video_enc_pkg::LUMA_W +: video_enc_pkg::LUMA_W];
        assign sel_amp   = amp_table_i[slot*video_enc_pkg::AMP_W +: video_enc_pkg::AMP_W];
        assign sel_phase = phase_table_i[slot*video_enc_pkg::PHASE_W +: video_enc_pkg::PHASE_W];

        always_comb begin
                if (burst_i) begin  // colour burst overrides the palette
                        next_amp   = video_enc_pkg::BURST_AMP;
                        base_phase = video_enc_pkg::BURST_PHASE;
                end else begin
                        next_amp   = sel_amp;
                        base_phase = sel_phase;
                end
                // pal alternation, 256 minus offset wraps to 0 for offset 0
                next_phase = oddline_i ? -base_phase : base_phase;
        end

        always_ff @(posedge clk_col16x or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        luma_o  <= '0;
                        amp_o   <= '0;
                        phase_o <= '0;
                        blank_o <= 1'b0;
                        sync_o  <= 1'b0;
                        burst_o <= 1'b0;
                end else begin
                        luma_o  <= sel_luma;
                        amp_o   <= next_amp;
                        phase_o <= next_phase;
                        blank_o <= blank_i;
                        sync_o  <= sync_i;
                        burst_o <= burst_i;
                end
        end

endmodule

`default_nettype wire

// File: source/composite_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module composite_encoder_top #(
        parameter int unsigned CARRIER_STEP = 16,
        parameter int          DAC_W        = 8
) (
        input  wire                                   clk_col16x,
        input  wire                                   rst_n_i,
        input  wire  [video_enc_pkg::INDEX_W-1:0]     index_i,
        input  wire                                   oddline_i,
        input  wire                                   blank_i,
        input  wire                                   sync_i,
        input  wire                                   burst_i,
        input  var   video_enc_pkg::luma_table_t      luma_table_i,
        input  var   video_enc_pkg::amp_table_t       amp_table_i,
        input  var   video_enc_pkg::phase_table_t     phase_table_i,
        output logic [video_enc_pkg::LUMA_W-1:0]      luma_o,
        output logic [DAC_W-1:0]                      chroma_o,
        output logic [DAC_W-1:0]                      composite_o
);

        video_enc_pkg::luma_table_t  luma_table_s;
        video_enc_pkg::amp_table_t   amp_table_s;
        video_enc_pkg::phase_table_t phase_table_s;

        logic        [video_enc_pkg::LUMA_W-1:0]   lut_luma;
        logic        [video_enc_pkg::AMP_W-1:0]    lut_amp;
        logic        [video_enc_pkg::PHASE_W-1:0]  lut_phase;
        logic                                      lut_blank;
        logic                                      lut_sync;
        logic                                      lut_burst;
        logic        [video_enc_pkg::PHASE_W-1:0]  carrier_phase;
        logic        [video_enc_pkg::LUMA_W-1:0]   mod_luma;
        logic signed [video_enc_pkg::CHROMA_W-1:0] mod_chroma;
        logic                                      mod_blank;
        logic                                      mod_sync;
        logic                                      mod_burst;

        // table resync, two clocks from capture to lookup
        palette_sync #(.table_t(video_enc_pkg::luma_table_t)) u_luma_sync (
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .table_i(luma_table_i), .table_o(luma_table_s));

        palette_sync #(.table_t(video_enc_pkg::amp_table_t)) u_amp_sync (
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .table_i(amp_table_i), .table_o(amp_table_s));

        palette_sync #(.table_t(video_enc_pkg::phase_table_t)) u_phase_sync (
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .table_i(phase_table_i), .table_o(phase_table_s));

        color_lookup u_lookup (  // stage 1
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .index_i(index_i), .oddline_i(oddline_i),
                .blank_i(blank_i), .sync_i(sync_i), .burst_i(burst_i),
                .luma_table_i(luma_table_s), .amp_table_i(amp_table_s),
                .phase_table_i(phase_table_s),
                .luma_o(lut_luma), .amp_o(lut_amp), .phase_o(lut_phase),
                .blank_o(lut_blank), .sync_o(lut_sync), .burst_o(lut_burst));

        subcarrier_gen #(.CARRIER_STEP(CARRIER_STEP)) u_carrier (
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .carrier_phase_o(carrier_phase));

        chroma_modulator u_modulator (  // stage 2
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .luma_i(lut_luma), .amp_i(lut_amp), .phase_i(lut_phase),
                .carrier_phase_i(carrier_phase),
                .blank_i(lut_blank), .sync_i(lut_sync), .burst_i(lut_burst),
                .luma_o(mod_luma), .chroma_o(mod_chroma),
                .blank_o(mod_blank), .sync_o(mod_sync), .burst_o(mod_burst));

        composite_mixer #(.DAC_W(DAC_W)) u_mixer (  // stage 3
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .luma_i(mod_luma), .chroma_i(mod_chroma),
                .blank_i(mod_blank), .sync_i(mod_sync), .burst_i(mod_burst),
                .luma_o(luma_o), .chroma_o(chroma_o), .composite_o(composite_o));

endmodule

`default_nettype wire

// File: source/composite_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module composite_mixer #(
        parameter int DAC_W = 8
) (
        input  wire                                        clk_col16x,
        input  wire                                        rst_n_i,
        input  wire        [video_enc_pkg::LUMA_W-1:0]     luma_i,
        input  wire signed [video_enc_pkg::CHROMA_W-1:0]   chroma_i,
        input  wire                                        blank_i,
        input  wire                                        sync_i,
        input  wire                                        burst_i,
        output logic       [video_enc_pkg::LUMA_W-1:0]     luma_o,
        output logic       [DAC_W-1:0]                     chroma_o,
        output logic       [DAC_W-1:0]                     composite_o
);

        localparam int DAC_MAX = (1 << DAC_W) - 1;

        logic        [video_enc_pkg::LUMA_W-1:0]   luma_mix;
        logic signed [video_enc_pkg::CHROMA_W-1:0] chroma_mix;
        logic signed [10:0]                        sum;
        logic        [DAC_W-1:0]                   comp_sat;

        always_comb begin
                luma_mix   = luma_i;
                chroma_mix = chroma_i;
                if (sync_i) begin  // sync tip
                        luma_mix   = '0;
                        chroma_mix = '0;
                end else if (blank_i) begin
                        luma_mix = video_enc_pkg::BLANK_LUMA;
                        if (!burst_i)
                                chroma_mix = '0;  // burst rides on the blank level
                end
                sum = $signed({3'b000, luma_mix, 2'b00}) + chroma_mix;  // 4 * luma + chroma
                if (sum < 0)
                        comp_sat = '0;
                else if (sum > DAC_MAX)
                        comp_sat = '1;
                else
                        comp_sat = DAC_W'(sum);
        end

        always_ff @(posedge clk_col16x or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        luma_o      <= '0;
                        chroma_o    <= '0;
                        composite_o <= '0;
                end else begin
                        luma_o      <= luma_mix;
                        chroma_o    <= DAC_W'(chroma_mix) + DAC_W'(1 << (DAC_W - 1));  // offset binary
                        composite_o <= comp_sat;
                end
        end

endmodule

`default_nettype wire

// File: source/palette_sync.sv
`timescale 1ns/1ps
`default_nettype none

// brings one quasi-static table over from the register clock
module palette_sync #(
        parameter type table_t = logic [7:0]
) (
        input  wire    clk_col16x,
        input  wire    rst_n_i,
        input  var     table_t table_i,
        output table_t table_o
);

        table_t meta_q;  // first stage, may go metastable

        always_ff @(posedge clk_col16x or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        meta_q  <= '0;
                        table_o <= '0;
                end else begin
                        meta_q  <= table_i;
                        table_o <= meta_q;
                end
        end

endmodule

`default_nettype wire

// File: source/subcarrier_gen.sv
`timescale 1ns/1ps
`default_nettype none

module subcarrier_gen #(
        parameter int unsigned CARRIER_STEP = 16  // phase advance per clock
) (
        input  wire                                 clk_col16x,
        input  wire                                 rst_n_i,
        output logic [video_enc_pkg::PHASE_W-1:0]   carrier_phase_o
);

        localparam logic [video_enc_pkg::PHASE_W-1:0] STEP =
                video_enc_pkg::PHASE_W'(CARRIER_STEP);

        // wraps modulo 256, one turn every 256/STEP clocks
        always_ff @(posedge clk_col16x or negedge rst_n_i) begin
                if (!rst_n_i)
                        carrier_phase_o <= '0;
                else
                        carrier_phase_o <= carrier_phase_o + STEP;
        end

endmodule

`default_nettype wire

// File: source/video_enc_pkg.sv
`default_nettype none

package video_enc_pkg;

        localparam int INDEX_W    = 4;
        localparam int LUMA_W     = 6;
        localparam int AMP_W      = 3;  // 0 is full scale, each step halves
        localparam int PHASE_W    = 8;  // 256 steps per turn
        localparam int CHROMA_W   = 8;  // signed sine samples
        localparam int NUM_COLORS = 16;

        // flattened tables from the register domain, entry 0 in the top field
        typedef logic [NUM_COLORS*LUMA_W-1:0]  luma_table_t;
        typedef logic [NUM_COLORS*AMP_W-1:0]   amp_table_t;
        typedef logic [NUM_COLORS*PHASE_W-1:0] phase_table_t;

        localparam logic [INDEX_W-1:0] BLACK       = 4'd0;
        localparam logic [INDEX_W-1:0] WHITE       = 4'd1;
        localparam logic [INDEX_W-1:0] RED         = 4'd2;
        localparam logic [INDEX_W-1:0] CYAN        = 4'd3;
        localparam logic [INDEX_W-1:0] PURPLE      = 4'd4;
        localparam logic [INDEX_W-1:0] GREEN       = 4'd5;
        localparam logic [INDEX_W-1:0] BLUE        = 4'd6;
        localparam logic [INDEX_W-1:0] YELLOW      = 4'd7;
        localparam logic [INDEX_W-1:0] ORANGE      = 4'd8;
        localparam logic [INDEX_W-1:0] BROWN       = 4'd9;
        localparam logic [INDEX_W-1:0] PINK        = 4'd10;
        localparam logic [INDEX_W-1:0] DARK_GREY   = 4'd11;
        localparam logic [INDEX_W-1:0] GREY        = 4'd12;
        localparam logic [INDEX_W-1:0] LIGHT_GREEN = 4'd13;
        localparam logic [INDEX_W-1:0] LIGHT_BLUE  = 4'd14;
        localparam logic [INDEX_W-1:0] LIGHT_GREY  = 4'd15;

        localparam logic [PHASE_W-1:0] BURST_PHASE = 8'd128;  // 180 deg
        localparam logic [AMP_W-1:0]   BURST_AMP   = 3'd2;
        localparam logic [AMP_W-1:0]   AMP_OFF     = 3'd7;    // no modulation
        localparam logic [LUMA_W-1:0]  BLANK_LUMA  = 6'd16;

        // one full period, 127 * sin(2*pi*k/64) rounded
        localparam logic signed [CHROMA_W-1:0] SINE_TABLE [64] = '{
                   8'sd0,    8'sd12,   8'sd25,   8'sd37,   8'sd49,   8'sd60,   8'sd71,   8'sd81,
                   8'sd90,   8'sd98,   8'sd106,  8'sd112,  8'sd117,  8'sd122,  8'sd125,  8'sd126,
                   8'sd127,  8'sd126,  8'sd125,  8'sd122,  8'sd117,  8'sd112,  8'sd106,  8'sd98,
                   8'sd90,   8'sd81,   8'sd71,   8'sd60,   8'sd49,   8'sd37,   8'sd25,   8'sd12,
                   8'sd0,   -8'sd12,  -8'sd25,  -8'sd37,  -8'sd49,  -8'sd60,  -8'sd71,  -8'sd81,
                  -8'sd90,  -8'sd98,  -8'sd106, -8'sd112, -8'sd117, -8'sd122, -8'sd125, -8'sd126,
                  -8'sd127, -8'sd126, -8'sd125, -8'sd122, -8'sd117, -8'sd112, -8'sd106, -8'sd98,
                  -8'sd90,  -8'sd81,  -8'sd71,  -8'sd60,  -8'sd49,  -8'sd37,  -8'sd25,  -8'sd12
        };

        // reference palette, indexed BLACK .. LIGHT_GREY
        localparam logic [LUMA_W-1:0] REF_LUMA [NUM_COLORS] = '{
                6'd19, 6'd59, 6'd31, 6'd44, 6'd34, 6'd39, 6'd28, 6'd50,
                6'd34, 6'd28, 6'd39, 6'd31, 6'd38, 6'd50, 6'd38, 6'd44
        };

        localparam logic [AMP_W-1:0] REF_AMP [NUM_COLORS] = '{
                3'd7, 3'd7, 3'd2, 3'd2, 3'd1, 3'd1, 3'd2, 3'd0,
                3'd0, 3'd2, 3'd2, 3'd7, 3'd7, 3'd2, 3'd2, 3'd7
        };

        // even-line offsets, odd lines use 256 minus these
        localparam logic [PHASE_W-1:0] REF_PHASE [NUM_COLORS] = '{
                8'd0,   8'd0,   8'd80, 8'd208, 8'd32, 8'd160, 8'd0, 8'd128,
                8'd96,  8'd112, 8'd80, 8'd0,   8'd0,  8'd160, 8'd0, 8'd0
        };

endpackage

`default_nettype wire

// File: verification/composite_encoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module composite_encoder_tb;

        localparam int unsigned CARRIER_STEP = 16;
        localparam int          DAC_W        = 8;
        localparam int          RESET_CYCLES = 10;
        localparam int          PHASE_LEN    = 240;  // cycles per test phase
        localparam int          NUM_PHASES   = 5;
        localparam int          TEST_CYCLES  = PHASE_LEN * NUM_PHASES;
        localparam int          CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + 50;
        localparam int unsigned SEED         = 57438;
        localparam int          LAST         = video_enc_pkg::NUM_COLORS - 1;

        logic                                  clk_col16x;
        logic                                  rst_n_i;
        logic [video_enc_pkg::INDEX_W-1:0]     index_i;
        logic                                  oddline_i;
        logic                                  blank_i;
        logic                                  sync_i;
        logic                                  burst_i;
        video_enc_pkg::luma_table_t            luma_table_i;
        video_enc_pkg::amp_table_t             amp_table_i;
        video_enc_pkg::phase_table_t           phase_table_i;
        wire  [video_enc_pkg::LUMA_W-1:0]      luma_o;
        wire  [DAC_W-1:0]                      chroma_o;
        wire  [DAC_W-1:0]                      composite_o;

        logic [21:0] expect_q [$];  // {luma, chroma, composite} per pixel in flight

        // tables as seen by the lookup stage, and the ones still crossing over
        int luma_cur [16];
        int amp_cur [16];
        int phase_cur [16];
        int luma_pend [16];
        int amp_pend [16];
        int phase_pend [16];
        int pend_cnt = 0;

        int          cycle = 0;  // falling edges since reset release
        int          ticks = 0;
        int          phase_sel;
        int          mismatches = 0;
        int          other_fails = 0;
        int          sat_hi = 0;
        int          sat_lo = 0;
        int          amp_off_seen = 0;
        int unsigned seed_val;

        composite_encoder_top #(
                .CARRIER_STEP(CARRIER_STEP),
                .DAC_W(DAC_W)
        ) UUT (
                .clk_col16x(clk_col16x), .rst_n_i(rst_n_i),
                .index_i(index_i), .oddline_i(oddline_i),
                .blank_i(blank_i), .sync_i(sync_i), .burst_i(burst_i),
                .luma_table_i(luma_table_i), .amp_table_i(amp_table_i),
                .phase_table_i(phase_table_i),
                .luma_o(luma_o), .chroma_o(chroma_o), .composite_o(composite_o));

        initial begin
                clk_col16x = 1'b0;
                forever #2 clk_col16x = ~clk_col16x;
        end

        // run limit
        always @(posedge clk_col16x) begin
                ticks++;
                if (ticks >= CYCLE_LIMIT) begin
                        $display("timeout: run still going after %0d clock cycles", CYCLE_LIMIT);
                        $display("tests failed");
                        $finish;
                end
        end

        // reference output for one pixel, built from the encoder rules
        function automatic logic [21:0] model_pixel(input int idx, input bit odd,
                                                   input bit blank, input bit sync,
                                                   input bit burst, input int carrier);
                int luma;
                int amp;
                int phase;
                int chroma;
                int comp;
                luma   = luma_cur[idx];
                amp    = burst ? int'(video_enc_pkg::BURST_AMP) : amp_cur[idx];
                phase  = burst ? int'(video_enc_pkg::BURST_PHASE) : phase_cur[idx];
                if (odd)
                        phase = (256 - phase) % 256;  // pal mirror
                chroma = video_enc_pkg::SINE_TABLE[((carrier + phase) % 256) / 4];
                if (amp == 7)
                        chroma = 0;
                else
                        chroma = chroma >>> amp;
                if (amp == 7 && !blank && !sync)
                        amp_off_seen++;
                if (sync) begin
                        luma   = 0;
                        chroma = 0;
                end else if (blank) begin
                        luma = video_enc_pkg::BLANK_LUMA;
                        if (!burst)
                                chroma = 0;
                end
                comp = 4 * luma + chroma;
                if (comp < 0) begin
                        comp = 0;
                        sat_lo++;
                end else if (comp > 255) begin
                        comp = 255;
                        sat_hi++;
                end
                return {6'(luma), 8'(chroma + 128), 8'(comp)};
        endfunction

        // 0 reference palette, 1 random, 2 luma extremes at full amplitude
        task automatic load_tables(input int mode);
                int i;
                for (i = 0; i <= LAST; i++) begin
                        if (mode == 0) begin
                                luma_pend[i]  = video_enc_pkg::REF_LUMA[i];
                                amp_pend[i]   = video_enc_pkg::REF_AMP[i];
                                phase_pend[i] = video_enc_pkg::REF_PHASE[i];
                        end else if (mode == 1) begin
                                luma_pend[i]  = $urandom_range(63);
                                amp_pend[i]   = $urandom_range(7);
                                phase_pend[i] = $urandom_range(255);
                        end else begin
                                luma_pend[i]  = (i % 2) ? 63 : 0;
                                amp_pend[i]   = 0;
                                phase_pend[i] = $urandom_range(255);
                        end
                        // entry 0 lands in the top field
                        luma_table_i[(LAST-i)*6 +: 6]  = 6'(luma_pend[i]);
                        amp_table_i[(LAST-i)*3 +: 3]   = 3'(amp_pend[i]);
                        phase_table_i[(LAST-i)*8 +: 8] = 8'(phase_pend[i]);
                end
                pend_cnt = 2;  // two flops before the lookup sees them
        endtask

        task automatic age_tables();
                if (pend_cnt > 0) begin
                        pend_cnt--;
                        if (pend_cnt == 0) begin
                                luma_cur  = luma_pend;
                                amp_cur   = amp_pend;
                                phase_cur = phase_pend;
                        end
                end
        endtask

        task automatic check_outputs();
                logic [21:0] exp;
                int          idle_chroma;
                if (cycle < 3) begin  // reset values, then empty pipeline slots
                        // an empty slot carries zero chroma, which sits at mid scale
                        idle_chroma = (cycle == 0) ? 0 : 128;
                        assert (luma_o == 0 && chroma_o == idle_chroma && composite_o == 0)
                        else begin
                                mismatches++;
                                $display("ERROR %0t: idle outputs wrong, got %0d %0d %0d",
                                         $time, luma_o, chroma_o, composite_o);
                        end
                end else begin
                        exp = expect_q.pop_front();
                        assert (luma_o == exp[21:16] && chroma_o == exp[15:8]
                                && composite_o == exp[7:0])
                        else begin
                                mismatches++;
                                $display("ERROR %0t: outputs %0d %0d %0d, expected %0d %0d %0d",
                                         $time, luma_o, chroma_o, composite_o,
                                         exp[21:16], exp[15:8], exp[7:0]);
                        end
                end
        endtask

        initial begin
                seed_val      = $urandom(SEED);
                rst_n_i       = 1'b0;
                index_i       = '0;
                oddline_i     = 1'b0;
                blank_i       = 1'b0;
                sync_i        = 1'b0;
                burst_i       = 1'b0;
                luma_table_i  = '0;
                amp_table_i   = '0;
                phase_table_i = '0;

                repeat (RESET_CYCLES - 1) begin
                        @(negedge clk_col16x);
                        check_outputs();
                end

                repeat (TEST_CYCLES) begin
                        @(negedge clk_col16x);
                        rst_n_i = 1'b1;
                        check_outputs();
                        age_tables();
                        phase_sel = cycle / PHASE_LEN;
                        if (cycle == 0)
                                load_tables(0);
                        else if (phase_sel == 3 && cycle % 40 == 0)
                                load_tables(1);  // reprogram mid-run
                        else if (cycle == 4 * PHASE_LEN)
                                load_tables(2);
                        index_i   = 4'($urandom_range(15));
                        oddline_i = (phase_sel == 1)
                                    || (phase_sel >= 2 && $urandom_range(1) == 1);
                        blank_i   = (phase_sel == 2 || phase_sel == 3) && $urandom_range(3) == 0;
                        sync_i    = blank_i && $urandom_range(3) == 0;
                        burst_i   = blank_i && !sync_i && $urandom_range(1) == 1;
                        expect_q.push_back(model_pixel(index_i, oddline_i, blank_i, sync_i,
                                                       burst_i, (CARRIER_STEP * (cycle + 1)) % 256));
                        cycle++;
                end

                blank_i = 1'b0;
                sync_i  = 1'b0;
                burst_i = 1'b0;
                repeat (3) begin  // drain the pixels in flight
                        @(negedge clk_col16x);
                        check_outputs();
                end

                assert (sat_hi > 0 && sat_lo > 0 && amp_off_seen > 0)
                else begin
                        other_fails++;
                        $display("composite saturation or unmodulated colours were never exercised");
                end

                $display("errors: %0d value mismatches, %0d other failures",
                         mismatches, other_fails);
                if (mismatches == 0 && other_fails == 0)
                        $display("all tests passed");
                else
                        $display("tests failed");
                $finish;
        end

endmodule

`default_nettype wire
